// File: sources.f
src/ntm_arith_pkg.sv
src/ntm_ctrl_pkg.sv
src/ntm_buffer_if.sv
src/ntm_index_counter.sv
src/ntm_vector_buffer.sv
src/ntm_dot_accumulator.sv
src/ntm_vector_logistic.sv
src/ntm_forget_fsm.sv
src/ntm_forget_gate_vector.sv
testbench/ntm_forget_gate_assert.sv
testbench/ntm_forget_gate_tb.sv

// File: Makefile
# Verilator build and run of the forget gate testbench.
# Pass or fail comes from the pass line in the simulation log.

VERILATOR ?= verilator
TOP       ?= ntm_forget_gate_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Everything OK
VFLAGS    ?= --binary --assert --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/ntm_forget_gate_tb.sv
/*
 * Testbench for the forget gate vector. Runs a fixed list of jobs back to
 * back, answers every pull request from LFSR operands, and compares each
 * F_OUT with a Q8.8 model of the gate. Protocol timing sits in the bound checker.
 */

module ntm_forget_gate_tb;
  import ntm_arith_pkg::*;

  localparam int MAX_SIZE = 8;
  localparam int SIZE_W   = $clog2(MAX_SIZE + 1);
  localparam int NUM_RUNS = 7;

  // Stream numbers, same order as the request bits below
  localparam int S_X = 0;
  localparam int S_R = 1;
  localparam int S_H = 2;
  localparam int S_W = 3;
  localparam int S_K = 4;
  localparam int S_U = 5;
  localparam int S_B = 6;

  // Job list, no reset in between
  localparam int RUN_SX   [NUM_RUNS] = '{2, 3, 4, 3, 1, 8, 1};
  localparam int RUN_SW   [NUM_RUNS] = '{2, 2, 3, 4, 1, 8, 1};
  localparam int RUN_SL   [NUM_RUNS] = '{2, 4, 3, 2, 1, 8, 1};
  localparam int RUN_MODE [NUM_RUNS] = '{0, 0, 1, 2, 0, 0, 0};  // 0 random, 1 high, 2 low
  localparam bit RUN_SLOW [NUM_RUNS] = '{0, 1, 1, 1, 1, 1, 0};  // LFSR answer delays

  logic              CLK, RST, START, READY;
  logic [SIZE_W-1:0] SIZE_X_IN, SIZE_W_IN, SIZE_L_IN;
  logic              X_IN_ENABLE, R_IN_ENABLE, H_IN_ENABLE, W_IN_ENABLE;
  logic              K_IN_ENABLE, U_IN_ENABLE, B_IN_ENABLE;
  logic              X_OUT_ENABLE, R_OUT_ENABLE, H_OUT_ENABLE, W_OUT_ENABLE;
  logic              K_OUT_ENABLE, U_OUT_ENABLE, B_OUT_ENABLE;
  data_t             X_IN, R_IN, H_IN, W_IN, K_IN, U_IN, B_IN;
  logic              F_OUT_ENABLE;
  data_t             F_OUT;

  logic [31:0] lfsr;
  data_t       stream [7][MAX_SIZE*MAX_SIZE];  // Operands of the current job
  int          taken [7];                      // Elements already answered
  data_t       expected_q [$];                 // One model value per row
  data_t       expected;
  int          cur_sx, cur_sw, cur_sl, cur_mode;
  bit          slow;
  logic [6:0]  requests;
  logic        pending;
  int          pending_kind;
  int          wait_cycles;
  int          rows_seen, runs_done;
  int          cycles, cycle_limit;

  ntm_forget_gate_vector #(.MAX_SIZE(MAX_SIZE)) uut (.*);

  assign requests = {B_OUT_ENABLE, U_OUT_ENABLE, K_OUT_ENABLE, W_OUT_ENABLE,
                     H_OUT_ENABLE, R_OUT_ENABLE, X_OUT_ENABLE};

  always #5 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1);
  endtask

  // Galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic data_t operand(input int mode, input bit is_weight);
    logic [15:0] bits;
    case (mode)
      1: return DATA_MAX;                               // Drives z to the top
      2: return is_weight ? DATA_MIN : DATA_MAX;        // Large negative products
      default: begin
        bits = random_bits(8);
        return data_t'({{8{bits[7]}}, bits[7:0]});     // About -0.5 to 0.5
      end
    endcase
  endfunction

  // f = clamp((sat(acc >> 8) >> 2) + 0.5, 0, 1) over one row
  function automatic data_t expected_f(input int l);
    longint acc;
    longint z;
    longint f;
    acc = 0;
    for (int j = 0; j < cur_sx; j++) begin
      acc += longint'(stream[S_W][l*cur_sx+j]) * longint'(stream[S_X][j]);
    end
    for (int j = 0; j < cur_sw; j++) begin
      acc += longint'(stream[S_K][l*cur_sw+j]) * longint'(stream[S_R][j]);
    end
    for (int j = 0; j < cur_sl; j++) begin
      acc += longint'(stream[S_U][l*cur_sl+j]) * longint'(stream[S_H][j]);
    end
    acc += longint'(stream[S_B][l]) <<< FRAC_BITS;
    z = acc >>> FRAC_BITS;
    if (z > 32767) z = 32767;
    else if (z < -32768) z = -32768;
    f = (z >>> 2) + longint'(LOGISTIC_HALF);
    if (f < 0) f = 0;
    else if (f > longint'(LOGISTIC_ONE)) f = longint'(LOGISTIC_ONE);
    return data_t'(f);
  endfunction

  // Request, then up to 3 extra wait cycles, per element
  function automatic int worst_cycles(input int sx, input int sw, input int sl);
    int elems;
    elems = sx + sw + sl + sl * (sx + sw + sl + 1);
    return 5 * elems + 4 * sl + 10;
  endfunction

  task automatic drive_data(input data_t value);
    X_IN = value;  // Only the enabled lane is looked at
    R_IN = value;
    H_IN = value;
    W_IN = value;
    K_IN = value;
    U_IN = value;
    B_IN = value;
  endtask

  task automatic prepare_run(input int run);
    int len [7];
    cur_sx   = RUN_SX[run];
    cur_sw   = RUN_SW[run];
    cur_sl   = RUN_SL[run];
    cur_mode = RUN_MODE[run];
    slow     = RUN_SLOW[run];
    len = '{cur_sx, cur_sw, cur_sl, cur_sl * cur_sx, cur_sl * cur_sw, cur_sl * cur_sl, cur_sl};
    for (int s = 0; s < 7; s++) begin
      taken[s] = 0;
      for (int n = 0; n < len[s]; n++) begin
        stream[s][n] = operand(cur_mode, s >= S_W);
      end
    end
    for (int l = 0; l < cur_sl; l++) begin
      expected_q.push_back(expected_f(l));
    end
    SIZE_X_IN = SIZE_W'(cur_sx);
    SIZE_W_IN = SIZE_W'(cur_sw);
    SIZE_L_IN = SIZE_W'(cur_sl);
  endtask

  ////////////////////////////////////////////////////////////
  // Operand source
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    #1;
    {B_IN_ENABLE, U_IN_ENABLE, K_IN_ENABLE, W_IN_ENABLE,
     H_IN_ENABLE, R_IN_ENABLE, X_IN_ENABLE} = '0;
    if (pending) begin
      if (wait_cycles == 0) begin
        drive_data(stream[pending_kind][taken[pending_kind]]);
        taken[pending_kind]++;
        {B_IN_ENABLE, U_IN_ENABLE, K_IN_ENABLE, W_IN_ENABLE,
         H_IN_ENABLE, R_IN_ENABLE, X_IN_ENABLE} = 7'b1 << pending_kind;
        pending = 1'b0;
      end else begin
        wait_cycles--;
      end
    end
    if (|requests) begin  // Answer no earlier than next cycle
      for (int k = 0; k < 7; k++) begin
        if (requests[k]) pending_kind = k;
      end
      pending     = 1'b1;
      wait_cycles = slow ? int'(random_bits(2)) : 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output monitor and watchdog
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    #1;
    if (F_OUT_ENABLE) begin
      if (expected_q.size() == 0) begin
        abort_run("F_OUT_ENABLE came with no row left to produce");
      end else begin
        expected = expected_q.pop_front();
        assert (F_OUT == expected)
          else abort_run($sformatf("FAILED at time %0t: row %0d F_OUT %0d, expected %0d",
                                   $time, rows_seen, F_OUT, expected));
        assert ((cur_mode != 1 || F_OUT == LOGISTIC_ONE) && (cur_mode != 2 || F_OUT == 0))
          else abort_run($sformatf("FAILED at time %0t: F_OUT %0d did not saturate",
                                   $time, F_OUT));
        rows_seen++;
      end
    end
    if (READY) begin
      assert (rows_seen == cur_sl && expected_q.size() == 0)
        else abort_run($sformatf("FAILED at time %0t: READY after %0d rows, expected %0d",
                                 $time, rows_seen, cur_sl));
      rows_seen = 0;
      runs_done++;
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (uut.u_assert.failures != 0) abort_run("A protocol assertion on the gate failed");
    else if (cycles > cycle_limit) abort_run("Timeout: the gate did not finish its runs");
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    lfsr      = 32'h1169;
    CLK       = 1'b0;
    RST       = 1'b1;
    START     = 1'b0;
    SIZE_X_IN = '0;
    SIZE_W_IN = '0;
    SIZE_L_IN = '0;
    {B_IN_ENABLE, U_IN_ENABLE, K_IN_ENABLE, W_IN_ENABLE,
     H_IN_ENABLE, R_IN_ENABLE, X_IN_ENABLE} = '0;
    drive_data('0);
    pending   = 1'b0;
    rows_seen = 0;
    runs_done = 0;
    cycles    = 0;
    cycle_limit = 16 + 8 + 100;  // Reset, idle check, margin
    for (int i = 0; i < NUM_RUNS; i++) begin
      cycle_limit += worst_cycles(RUN_SX[i], RUN_SW[i], RUN_SL[i]) + 4;
    end

    repeat (16) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Idle gate stays silent
    repeat (6) begin
      @(posedge CLK);
      #1;
      assert (!(READY || F_OUT_ENABLE || |requests))
        else abort_run("An output strobe was high before START");
    end

    for (int i = 0; i < NUM_RUNS; i++) begin
      prepare_run(i);
      START = 1'b1;
      @(posedge CLK);
      #1;
      START = 1'b0;
      while (runs_done <= i) @(posedge CLK);
      #1;
    end

    if (uut.u_assert.failures != 0) begin
      abort_run("A protocol assertion on the gate failed");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: testbench/ntm_forget_gate_assert.sv
/*
 * Protocol checks for the pull interface of the forget gate, bound into the
 * top level. Strobe width, request overlap, output timing after the bias,
 * READY placement and output range.
 */

module ntm_forget_gate_assert (
  input logic                 CLK,
  input logic                 RST,
  input logic                 READY,
  input logic                 X_OUT_ENABLE,
  input logic                 R_OUT_ENABLE,
  input logic                 H_OUT_ENABLE,
  input logic                 W_OUT_ENABLE,
  input logic                 K_OUT_ENABLE,
  input logic                 U_OUT_ENABLE,
  input logic                 B_OUT_ENABLE,
  input logic                 X_IN_ENABLE,
  input logic                 R_IN_ENABLE,
  input logic                 H_IN_ENABLE,
  input logic                 W_IN_ENABLE,
  input logic                 K_IN_ENABLE,
  input logic                 U_IN_ENABLE,
  input logic                 B_IN_ENABLE,
  input logic                 F_OUT_ENABLE,
  input ntm_arith_pkg::data_t F_OUT
);
  import ntm_arith_pkg::*;

  logic [6:0] requests;
  logic [6:0] answers;
  logic       pending;       // Request sent and not yet answered
  int         failures = 0;  // Count of failed assertions

  assign requests = {X_OUT_ENABLE, R_OUT_ENABLE, H_OUT_ENABLE, W_OUT_ENABLE,
                     K_OUT_ENABLE, U_OUT_ENABLE, B_OUT_ENABLE};
  assign answers  = {X_IN_ENABLE, R_IN_ENABLE, H_IN_ENABLE, W_IN_ENABLE,
                     K_IN_ENABLE, U_IN_ENABLE, B_IN_ENABLE};

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) pending <= 1'b0;
    else if (|requests) pending <= 1'b1;
    else if (|answers) pending <= 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  one_request_at_a_time: assert property (@(posedge CLK) disable iff (RST)
    $onehot0(requests))
    else begin
      failures++;
      $error("Two request strobes high in one cycle");
    end

  strobe_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    |requests |=> ~|requests)
    else begin
      failures++;
      $error("Request strobe held longer than one cycle");
    end

  no_request_while_pending: assert property (@(posedge CLK) disable iff (RST)
    |requests |-> !pending)
    else begin
      failures++;
      $error("New request before the previous answer");
    end

  ////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////

  output_after_bias: assert property (@(posedge CLK) disable iff (RST)
    B_IN_ENABLE |-> ##2 F_OUT_ENABLE)
    else begin
      failures++;
      $error("No F_OUT_ENABLE two cycles after the bias");
    end

  output_only_after_bias: assert property (@(posedge CLK) disable iff (RST)
    F_OUT_ENABLE |-> $past(B_IN_ENABLE, 2))
    else begin
      failures++;
      $error("F_OUT_ENABLE without a bias two cycles before");
    end

  ready_with_last_output: assert property (@(posedge CLK) disable iff (RST)
    READY |-> F_OUT_ENABLE)
    else begin
      failures++;
      $error("READY without F_OUT_ENABLE");
    end

  output_in_range: assert property (@(posedge CLK) disable iff (RST)
    F_OUT_ENABLE |-> (F_OUT >= 0 && F_OUT <= LOGISTIC_ONE))
    else begin
      failures++;
      $error("F_OUT outside 0 to 1.0");
    end

endmodule

bind ntm_forget_gate_vector ntm_forget_gate_assert u_assert (
  .CLK         (CLK),
  .RST         (RST),
  .READY       (READY),
  .X_OUT_ENABLE(X_OUT_ENABLE),
  .R_OUT_ENABLE(R_OUT_ENABLE),
  .H_OUT_ENABLE(H_OUT_ENABLE),
  .W_OUT_ENABLE(W_OUT_ENABLE),
  .K_OUT_ENABLE(K_OUT_ENABLE),
  .U_OUT_ENABLE(U_OUT_ENABLE),
  .B_OUT_ENABLE(B_OUT_ENABLE),
  .X_IN_ENABLE (X_IN_ENABLE),
  .R_IN_ENABLE (R_IN_ENABLE),
  .H_IN_ENABLE (H_IN_ENABLE),
  .W_IN_ENABLE (W_IN_ENABLE),
  .K_IN_ENABLE (K_IN_ENABLE),
  .U_IN_ENABLE (U_IN_ENABLE),
  .B_IN_ENABLE (B_IN_ENABLE),
  .F_OUT_ENABLE(F_OUT_ENABLE),
  .F_OUT       (F_OUT)
);

// File: src/ntm_forget_gate_vector.sv
/*
 * Forget gate vector f(l) = sigmoid(W(l)x + K(l)r + U(l)h + b(l)), Q8.8.
 * Operands are pulled one element per *_OUT_ENABLE request; each row result
 * appears on F_OUT with F_OUT_ENABLE, READY marks the last row.
 */

module ntm_forget_gate_vector #(
  parameter int  MAX_SIZE = 8,  // Buffer depth and largest vector size
  localparam int SIZE_W   = $clog2(MAX_SIZE + 1)
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [SIZE_W-1:0]    SIZE_X_IN,    // Length of x
  input  logic [SIZE_W-1:0]    SIZE_W_IN,    // Length of r
  input  logic [SIZE_W-1:0]    SIZE_L_IN,    // Rows, and length of h
  input  logic                 X_IN_ENABLE,
  input  logic                 R_IN_ENABLE,
  input  logic                 H_IN_ENABLE,
  input  logic                 W_IN_ENABLE,
  input  logic                 K_IN_ENABLE,
  input  logic                 U_IN_ENABLE,
  input  logic                 B_IN_ENABLE,
  output logic                 X_OUT_ENABLE,
  output logic                 R_OUT_ENABLE,
  output logic                 H_OUT_ENABLE,
  output logic                 W_OUT_ENABLE,
  output logic                 K_OUT_ENABLE,
  output logic                 U_OUT_ENABLE,
  output logic                 B_OUT_ENABLE,
  input  ntm_arith_pkg::data_t X_IN,
  input  ntm_arith_pkg::data_t R_IN,
  input  ntm_arith_pkg::data_t H_IN,
  input  ntm_arith_pkg::data_t W_IN,
  input  ntm_arith_pkg::data_t K_IN,
  input  ntm_arith_pkg::data_t U_IN,
  input  ntm_arith_pkg::data_t B_IN,
  output logic                 F_OUT_ENABLE,
  output ntm_arith_pkg::data_t F_OUT
);
  import ntm_arith_pkg::*;

  localparam int IDX_W = (MAX_SIZE > 1) ? $clog2(MAX_SIZE) : 1;

  ////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////

  logic              row_clear, row_step, row_last;
  logic              elem_clear, elem_step, elem_last;
  logic [SIZE_W-1:0] elem_limit;
  logic [IDX_W-1:0]  elem_index;
  logic              acc_clear, mac_enable, bias_enable, activate;
  data_t             coef;
  data_t             element;
  acc_t              acc;

  ntm_buffer_if #(.MAX_SIZE(MAX_SIZE)) x_bus ();
  ntm_buffer_if #(.MAX_SIZE(MAX_SIZE)) r_bus ();
  ntm_buffer_if #(.MAX_SIZE(MAX_SIZE)) h_bus ();

  // Ports share names with the top and the wires above
  ntm_forget_fsm #(.MAX_SIZE(MAX_SIZE)) u_fsm (
    .*,
    .f_valid(F_OUT_ENABLE)
  );

  ntm_index_counter #(.MAX_SIZE(MAX_SIZE)) u_row_counter (
    .CLK  (CLK),
    .RST  (RST),
    .clear(row_clear),
    .step (row_step),
    .limit(SIZE_L_IN),
    .index(),  // Only the last-row flag matters
    .last (row_last)
  );

  ntm_index_counter #(.MAX_SIZE(MAX_SIZE)) u_elem_counter (
    .CLK  (CLK),
    .RST  (RST),
    .clear(elem_clear),
    .step (elem_step),
    .limit(elem_limit),
    .index(elem_index),
    .last (elem_last)
  );

  ntm_vector_buffer #(.MAX_SIZE(MAX_SIZE)) u_x_buffer (.CLK(CLK), .RST(RST), .bus(x_bus));
  ntm_vector_buffer #(.MAX_SIZE(MAX_SIZE)) u_r_buffer (.CLK(CLK), .RST(RST), .bus(r_bus));
  ntm_vector_buffer #(.MAX_SIZE(MAX_SIZE)) u_h_buffer (.CLK(CLK), .RST(RST), .bus(h_bus));

  ntm_dot_accumulator u_accumulator (
    .CLK        (CLK),
    .RST        (RST),
    .acc_clear  (acc_clear),
    .mac_enable (mac_enable),
    .bias_enable(bias_enable),
    .coef       (coef),
    .element    (element),
    .acc        (acc)
  );

  ntm_vector_logistic u_logistic (
    .CLK     (CLK),
    .RST     (RST),
    .activate(activate),
    .acc     (acc),
    .F_OUT   (F_OUT),
    .f_valid (F_OUT_ENABLE)
  );

endmodule

// File: src/ntm_forget_fsm.sv
/*
 * Sequencer of the forget gate. Pulls x, r and h into the buffers, then for
 * each row pulls W, K, U and b, feeding the accumulator one term per answer.
 * Requests are registered one-cycle strobes; at most one is outstanding.
 */

module ntm_forget_fsm #(
  parameter int  MAX_SIZE = 8,
  localparam int SIZE_W   = $clog2(MAX_SIZE + 1),
  localparam int IDX_W    = (MAX_SIZE > 1) ? $clog2(MAX_SIZE) : 1
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [SIZE_W-1:0]    SIZE_X_IN,
  input  logic [SIZE_W-1:0]    SIZE_W_IN,
  input  logic [SIZE_W-1:0]    SIZE_L_IN,
  input  logic                 X_IN_ENABLE,
  input  logic                 R_IN_ENABLE,
  input  logic                 H_IN_ENABLE,
  input  logic                 W_IN_ENABLE,
  input  logic                 K_IN_ENABLE,
  input  logic                 U_IN_ENABLE,
  input  logic                 B_IN_ENABLE,
  output logic                 X_OUT_ENABLE,
  output logic                 R_OUT_ENABLE,
  output logic                 H_OUT_ENABLE,
  output logic                 W_OUT_ENABLE,
  output logic                 K_OUT_ENABLE,
  output logic                 U_OUT_ENABLE,
  output logic                 B_OUT_ENABLE,
  input  ntm_arith_pkg::data_t X_IN,
  input  ntm_arith_pkg::data_t R_IN,
  input  ntm_arith_pkg::data_t H_IN,
  input  ntm_arith_pkg::data_t W_IN,
  input  ntm_arith_pkg::data_t K_IN,
  input  ntm_arith_pkg::data_t U_IN,
  input  ntm_arith_pkg::data_t B_IN,
  input  logic                 row_last,
  input  logic                 elem_last,
  input  logic [IDX_W-1:0]     elem_index,
  input  logic                 f_valid,     // Logistic output strobe
  output logic                 row_clear,
  output logic                 row_step,
  output logic                 elem_clear,
  output logic                 elem_step,
  output logic [SIZE_W-1:0]    elem_limit,  // Length of the current stream
  output logic                 acc_clear,
  output logic                 mac_enable,
  output logic                 bias_enable,
  output ntm_arith_pkg::data_t coef,
  output ntm_arith_pkg::data_t element,
  output logic                 activate,
  ntm_buffer_if.controller     x_bus,
  ntm_buffer_if.controller     r_bus,
  ntm_buffer_if.controller     h_bus
);
  import ntm_ctrl_pkg::*;

  fsm_state_t     state;
  fsm_state_t     after_elem;  // Successor once a stream is done
  operand_phase_t phase;
  logic           req_q;       // Request pending for the current state
  logic           act_q;       // Bias just landed, run the logistic
  logic           answer;

  ////////////////////////////////////////////////////////////
  // Stream decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (state)
      LOAD_X, ROW_W: phase = PHASE_X;
      LOAD_R, ROW_K: phase = PHASE_R;
      default:       phase = PHASE_H;
    endcase
    case (phase)
      PHASE_X: elem_limit = SIZE_X_IN;
      PHASE_R: elem_limit = SIZE_W_IN;  // r has one word per memory column
      default: elem_limit = SIZE_L_IN;
    endcase
  end

  always_comb begin
    case (state)  // Only the stream we asked for counts as an answer
      LOAD_X:  answer = X_IN_ENABLE;
      LOAD_R:  answer = R_IN_ENABLE;
      LOAD_H:  answer = H_IN_ENABLE;
      ROW_W:   answer = W_IN_ENABLE;
      ROW_K:   answer = K_IN_ENABLE;
      ROW_U:   answer = U_IN_ENABLE;
      BIAS:    answer = B_IN_ENABLE;
      default: answer = 1'b0;
    endcase
    case (state)
      LOAD_X:  after_elem = LOAD_R;
      LOAD_R:  after_elem = LOAD_H;
      LOAD_H:  after_elem = ROW_W;
      ROW_W:   after_elem = ROW_K;
      ROW_K:   after_elem = ROW_U;
      default: after_elem = BIAS;
    endcase
  end

  // Coefficient straight from the input, element from the matching buffer
  always_comb begin
    case (state)
      ROW_W:   coef = W_IN;
      ROW_K:   coef = K_IN;
      ROW_U:   coef = U_IN;
      default: coef = B_IN;  // Bias rides the coef lane
    endcase
    case (phase)
      PHASE_X: element = x_bus.read_data;
      PHASE_R: element = r_bus.read_data;
      default: element = h_bus.read_data;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////////////////////////

  assign X_OUT_ENABLE = req_q & (state == LOAD_X);
  assign R_OUT_ENABLE = req_q & (state == LOAD_R);
  assign H_OUT_ENABLE = req_q & (state == LOAD_H);
  assign W_OUT_ENABLE = req_q & (state == ROW_W);
  assign K_OUT_ENABLE = req_q & (state == ROW_K);
  assign U_OUT_ENABLE = req_q & (state == ROW_U);
  assign B_OUT_ENABLE = req_q & (state == BIAS);

  assign mac_enable  = answer & (state inside {ROW_W, ROW_K, ROW_U});
  assign bias_enable = answer & (state == BIAS);
  assign elem_step   = answer & (state != BIAS);
  assign elem_clear  = (state == IDLE) | (elem_step & elem_last);  // Wrap per stream
  assign row_clear   = (state == IDLE);
  assign row_step    = bias_enable & ~row_last;
  assign acc_clear   = (state == IDLE) | act_q;  // Logistic samples acc this same edge
  assign activate    = act_q;
  assign READY       = (state == FINISH) & f_valid;  // Coincides with last F_OUT_ENABLE

  // Buffer fill, index shared with the row read-back
  assign x_bus.write       = answer & (state == LOAD_X);
  assign x_bus.write_index = elem_index;
  assign x_bus.write_data  = X_IN;
  assign x_bus.read_index  = elem_index;
  assign r_bus.write       = answer & (state == LOAD_R);
  assign r_bus.write_index = elem_index;
  assign r_bus.write_data  = R_IN;
  assign r_bus.read_index  = elem_index;
  assign h_bus.write       = answer & (state == LOAD_H);
  assign h_bus.write_index = elem_index;
  assign h_bus.write_data  = H_IN;
  assign h_bus.read_index  = elem_index;

  ////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      req_q <= 1'b0;
      act_q <= 1'b0;
    end else begin
      req_q <= 1'b0;  // Strobes last one cycle
      act_q <= 1'b0;
      case (state)
        IDLE: begin
          if (START) begin
            state <= LOAD_X;
            req_q <= 1'b1;
          end
        end
        LOAD_X, LOAD_R, LOAD_H, ROW_W, ROW_K, ROW_U: begin
          if (answer) begin
            req_q <= 1'b1;  // Next element, or first of the next stream
            if (elem_last) state <= after_elem;
          end
        end
        BIAS: begin
          if (answer) begin
            act_q <= 1'b1;
            if (row_last) begin
              state <= ACTIVATE;
            end else begin
              state <= ROW_W;  // Next row overlaps the activation
              req_q <= 1'b1;
            end
          end
        end
        ACTIVATE: state <= FINISH;
        FINISH:   if (f_valid) state <= IDLE;
        default:  state <= IDLE;
      endcase
    end
  end

endmodule

// File: src/ntm_vector_logistic.sv
/*
 * Hard sigmoid stage. Brings the Q16.16 row sum back to Q8.8 with
 * saturation, computes z/4 + 1/2 clamped to [0, 1] and registers it.
 * One cycle from activate to f_valid.
 */

module ntm_vector_logistic (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 activate,
  input  ntm_arith_pkg::acc_t  acc,
  output ntm_arith_pkg::data_t F_OUT,
  output logic                 f_valid   // One-cycle result strobe
);
  import ntm_arith_pkg::*;

  acc_t  scaled;
  data_t z;
  data_t slope;  // Linear part of the sigmoid
  data_t f_next;

  assign scaled = acc >>> FRAC_BITS;

  always_comb begin
    if (scaled > acc_t'(DATA_MAX)) z = DATA_MAX;
    else if (scaled < acc_t'(DATA_MIN)) z = DATA_MIN;
    else z = data_t'(scaled);
  end

  assign slope = (z >>> 2) + LOGISTIC_HALF;  // Cannot overflow after the shift

  always_comb begin
    if (slope < 0) f_next = '0;
    else if (slope > LOGISTIC_ONE) f_next = LOGISTIC_ONE;
    else f_next = slope;
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) f_valid <= 1'b0;
    else f_valid <= activate;
  end

  always_ff @(posedge CLK) begin
    if (activate) F_OUT <= f_next;  // Holds until the next row
  end

endmodule

// File: src/ntm_dot_accumulator.sv
/*
 * Row accumulator of the forget gate.
 * Adds coef * element for each W, K and U term and the bias aligned to
 * Q16.16, one term per enable. acc_clear starts the next row.
 */

module ntm_dot_accumulator (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 acc_clear,
  input  logic                 mac_enable,
  input  logic                 bias_enable,
  input  ntm_arith_pkg::data_t coef,     // Weight, or bias when bias_enable
  input  ntm_arith_pkg::data_t element,
  output ntm_arith_pkg::acc_t  acc       // Q16.16 row sum
);
  import ntm_arith_pkg::*;

  logic signed [2*DATA_W-1:0] product;  // Q16.16, exact
  acc_t                       term;

  assign product = coef * element;

  always_comb begin
    if (bias_enable) begin
      term = acc_t'(coef) <<< FRAC_BITS;  // Q8.8 up to Q16.16
    end else begin
      term = acc_t'(product);  // Sign extended
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc <= '0;
    end else if (acc_clear) begin
      acc <= '0;
    end else if (mac_enable | bias_enable) begin
      acc <= acc + term;
    end
  end

endmodule

// File: src/ntm_vector_buffer.sv
/*
 * Operand vector store for x, r or h.
 * Written one element per strobe while the vector streams in, then read
 * back asynchronously by index once per row.
 */

module ntm_vector_buffer #(
  parameter int MAX_SIZE = 8
) (
  input logic          CLK,
  input logic          RST,
  ntm_buffer_if.storage bus
);
  import ntm_arith_pkg::*;

  data_t mem [MAX_SIZE];  // One word per element

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < MAX_SIZE; i++) begin
        mem[i] <= '0;
      end
    end else if (bus.write) begin
      mem[bus.write_index] <= bus.write_data;
    end
  end

  // Asynchronous read, element ready in the answer cycle
  assign bus.read_data = mem[bus.read_index];

endmodule

// File: src/ntm_index_counter.sv
/*
 * Index counter for rows or vector elements.
 * Steps from 0, flags the final index of a run of limit entries,
 * and returns to 0 on clear.
 */

module ntm_index_counter #(
  parameter int  MAX_SIZE = 8,
  localparam int SIZE_W   = $clog2(MAX_SIZE + 1),
  localparam int IDX_W    = (MAX_SIZE > 1) ? $clog2(MAX_SIZE) : 1
) (
  input  logic              CLK,
  input  logic              RST,
  input  logic              clear,  // Wins over step
  input  logic              step,
  input  logic [SIZE_W-1:0] limit,  // Run length, 1 to MAX_SIZE
  output logic [IDX_W-1:0]  index,
  output logic              last
);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      index <= '0;
    end else if (clear) begin
      index <= '0;
    end else if (step) begin
      index <= index + IDX_W'(1);
    end
  end

  // Widen index to the size range before comparing
  assign last = (SIZE_W'(index) == limit - SIZE_W'(1));

endmodule

// File: src/ntm_buffer_if.sv
/*
 * Link between the controller and one operand vector buffer.
 * The controller writes elements as they arrive and reads them back by index
 * during the row products; read_data follows read_index in the same cycle.
 */

interface ntm_buffer_if #(
  parameter int MAX_SIZE = 8
);
  import ntm_arith_pkg::*;

  localparam int IDX_W = (MAX_SIZE > 1) ? $clog2(MAX_SIZE) : 1;

  logic             write;        // One element per strobe
  logic [IDX_W-1:0] write_index;
  data_t            write_data;
  logic [IDX_W-1:0] read_index;
  data_t            read_data;    // Combinational from read_index

  modport controller(
    output write, write_index, write_data, read_index,
    input  read_data
  );

  modport storage(
    input  write, write_index, write_data, read_index,
    output read_data
  );

endinterface

// File: src/ntm_ctrl_pkg.sv
/*
 * Controller definitions for the forget gate.
 * State encoding of the sequencing FSM and the operand phase it serves.
 */

package ntm_ctrl_pkg;

  // One state per operand stream, then activation and handoff
  typedef enum logic [3:0] {
    IDLE,
    LOAD_X,    // fill x buffer
    LOAD_R,    // fill r buffer
    LOAD_H,    // fill h buffer
    ROW_W,     // W(l) . x
    ROW_K,     // K(l) . r
    ROW_U,     // U(l) . h
    BIAS,      // b(l)
    ACTIVATE,  // last row in the logistic stage
    FINISH     // wait for the last output
  } fsm_state_t;

  // Which vector, and which size, the current element stream belongs to
  typedef enum logic [1:0] {PHASE_X, PHASE_R, PHASE_H} operand_phase_t;

endpackage

// File: src/ntm_arith_pkg.sv
/*
 * Fixed-point definitions for the forget gate datapath.
 * Operands, bias and output are signed Q8.8; the row sum is kept in Q16.16.
 * Import into a module body where these types or constants are needed.
 */

package ntm_arith_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int DATA_W    = 16;  // Q8.8 word
  localparam int ACC_W     = 40;  // Q16.16 with headroom for long rows
  localparam int FRAC_BITS = 8;

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // Saturation bounds of data_t
  localparam data_t DATA_MAX = 16'sh7fff;
  localparam data_t DATA_MIN = 16'sh8000;

  // Hard sigmoid constants in Q8.8
  localparam data_t LOGISTIC_HALF = 16'sd128;  // 0.5
  localparam data_t LOGISTIC_ONE  = 16'sd256;  // 1.0

endpackage
